// File: include/rp_4adc_params.svh
/* widths, counts, address fields and ID word
   of the four-channel acquisition data path */
`ifndef RP_4ADC_PARAMS_SVH
`define RP_4ADC_PARAMS_SVH

`define RP_NUM_ADC     4             // adc channels
`define RP_ADC_DW      14            // adc sample width

// system bus
`define RP_SYS_AW      32
`define RP_SYS_DW      32
`define RP_REGION_W    3             // eight regions
`define RP_OFS_W       20            // offset inside a region

`define RP_PDM_W       8             // one pdm setting
`define RP_ID_WORD     32'h4adc_0001 // read at hk offset 0x00

`define RP_HK_REGION   0             // housekeeping region
`define RP_AMS_REGION  4             // analog mixed signals region

`endif

// File: design/rp_4adc_pkg.sv
/* shared types of the acquisition data path:
   adc words, bus words, pdm settings, region index */
package rp_4adc_pkg;

  `include "rp_4adc_params.svh"

  //////////////////////////////////////////////////
  // adc side
  //////////////////////////////////////////////////

  typedef logic        [`RP_ADC_DW-1:0]   adc_raw_t;    // offset binary, neg slope
  typedef logic signed [`RP_ADC_DW-1:0]   adc_sample_t; // two's complement

  //////////////////////////////////////////////////
  // system bus and config
  //////////////////////////////////////////////////

  typedef logic [`RP_SYS_AW-1:0]   sys_addr_t;
  typedef logic [`RP_SYS_DW-1:0]   sys_word_t;
  typedef logic [`RP_PDM_W-1:0]    pdm_cfg_t;   // duty setting, 0..255
  typedef logic [`RP_REGION_W-1:0] region_t;    // addr bits 22:20

endpackage

// File: design/sys_bus_if.sv
/* system bus, strobe/ack protocol without back-pressure */
`timescale 1ns/1ps

interface sys_bus_if;

  import rp_4adc_pkg::*;

  sys_addr_t addr;   // offset inside region
  sys_word_t wdata;
  logic      wen;    // one-cycle write strobe
  logic      ren;    // one-cycle read strobe
  sys_word_t rdata;
  logic      ack;    // one per strobe
  logic      err;

  // request side, decoder
  modport master (output addr, wdata, wen, ren,
                  input  rdata, ack, err);

  // register blocks
  modport slave  (input  addr, wdata, wen, ren,
                  output rdata, ack, err);

endinterface

// File: design/adc_sample_conv.sv
/* adc raw word to two's complement, two register stages */
`timescale 1ns/1ps
`include "rp_4adc_params.svh"

module adc_sample_conv (
  input  logic                                      adc_clk_01,
  input  logic                                      rst_n_i,
  input  rp_4adc_pkg::adc_raw_t    [`RP_NUM_ADC-1:0] adc_dat_raw_i,
  output rp_4adc_pkg::adc_sample_t [`RP_NUM_ADC-1:0] adc_dat_o
);

  import rp_4adc_pkg::*;

  adc_sample_t [`RP_NUM_ADC-1:0] conv_r;   // first stage

  // offset binary with negative slope
  // keep msb, invert the rest -> two's complement
  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      conv_r    <= '0;
      adc_dat_o <= '0;
    end else begin
      for (int ch = 0; ch < `RP_NUM_ADC; ch++) begin
        conv_r[ch] <= {adc_dat_raw_i[ch][`RP_ADC_DW-1],
                       ~adc_dat_raw_i[ch][`RP_ADC_DW-2:0]};
      end
      adc_dat_o <= conv_r;   // second stage, timing only
    end
  end

endmodule

// File: design/sys_bus_decode.sv
/* system bus decoder, splits requests into eight regions,
   registers slave responses and answers unmapped regions with err */
`timescale 1ns/1ps
`include "rp_4adc_params.svh"

module sys_bus_decode (
  input  logic                  adc_clk_01,
  input  logic                  rst_n_i,
  input  rp_4adc_pkg::sys_addr_t sys_addr_i,
  input  rp_4adc_pkg::sys_word_t sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output rp_4adc_pkg::sys_word_t sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  sys_bus_if.master             bus_hk_o,
  sys_bus_if.master             bus_ams_o
);

  import rp_4adc_pkg::*;

  region_t   region;
  logic      hit_hk, hit_ams;
  sys_addr_t addr_r;
  sys_word_t wdata_r;
  logic      hk_wen_r, hk_ren_r, ams_wen_r, ams_ren_r;
  logic      unmap_r, unmap_rr;   // error path, same latency as a slave

  assign region  = sys_addr_i[`RP_OFS_W +: `RP_REGION_W];
  assign hit_hk  = (region == region_t'(`RP_HK_REGION));
  assign hit_ams = (region == region_t'(`RP_AMS_REGION));

  //////////////////////////////////////////////////
  // request stage
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      hk_wen_r  <= 1'b0;
      hk_ren_r  <= 1'b0;
      ams_wen_r <= 1'b0;
      ams_ren_r <= 1'b0;
      unmap_r   <= 1'b0;
    end else begin
      hk_wen_r  <= sys_wen_i & hit_hk;
      hk_ren_r  <= sys_ren_i & hit_hk;
      ams_wen_r <= sys_wen_i & hit_ams;
      ams_ren_r <= sys_ren_i & hit_ams;
      unmap_r   <= (sys_wen_i | sys_ren_i) & ~hit_hk & ~hit_ams; // six dead regions
    end
  end

  // address and data only follow a strobe
  always_ff @(posedge adc_clk_01) begin
    if (sys_wen_i | sys_ren_i) begin
      addr_r  <= sys_addr_t'(sys_addr_i[`RP_OFS_W-1:0]); // strip region
      wdata_r <= sys_wdata_i;
    end
  end

  assign bus_hk_o.addr   = addr_r;
  assign bus_hk_o.wdata  = wdata_r;
  assign bus_hk_o.wen    = hk_wen_r;
  assign bus_hk_o.ren    = hk_ren_r;
  assign bus_ams_o.addr  = addr_r;
  assign bus_ams_o.wdata = wdata_r;
  assign bus_ams_o.wen   = ams_wen_r;
  assign bus_ams_o.ren   = ams_ren_r;

  //////////////////////////////////////////////////
  // response stage
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      unmap_rr    <= 1'b0;
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      unmap_rr  <= unmap_r;   // stands in for the slave ack cycle
      sys_ack_o <= bus_hk_o.ack | bus_ams_o.ack | unmap_rr;
      sys_err_o <= (bus_hk_o.ack & bus_hk_o.err) | (bus_ams_o.ack & bus_ams_o.err) | unmap_rr;
      if (bus_hk_o.ack)       sys_rdata_o <= bus_hk_o.rdata;
      else if (bus_ams_o.ack) sys_rdata_o <= bus_ams_o.rdata;
      else                    sys_rdata_o <= '0; // unmapped reads zero
    end
  end

  // master never issues read and write together
  a_one_strobe: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    !(sys_wen_i && sys_ren_i));

  // slaves answer exactly one cycle after their strobe
  a_hk_ack: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    (hk_wen_r || hk_ren_r) |=> bus_hk_o.ack);
  a_ams_ack: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    (ams_wen_r || ams_ren_r) |=> bus_ams_o.ack);

endmodule

// File: design/hk_regs.sv
/* housekeeping registers, ID word and read-back of converted samples */
`timescale 1ns/1ps
`include "rp_4adc_params.svh"

module hk_regs (
  input  logic                                      adc_clk_01,
  input  logic                                      rst_n_i,
  sys_bus_if.slave                                  bus_i,
  input  rp_4adc_pkg::adc_sample_t [`RP_NUM_ADC-1:0] adc_dat_i
);

  import rp_4adc_pkg::*;

  logic [`RP_OFS_W-1:0] ofs;
  adc_sample_t          smp;
  sys_word_t            rdata_d;

  assign ofs = bus_i.addr[`RP_OFS_W-1:0];
  assign smp = adc_dat_i[ofs[3:2]];   // 0x10..0x1c -> ch 0..3

  // read mux
  always_comb begin
    rdata_d = '0;   // holes read zero
    if (ofs == '0)
      rdata_d = `RP_ID_WORD;
    else if ((ofs[`RP_OFS_W-1:4] == 'h1) && (ofs[1:0] == 2'b00))
      rdata_d = {{(`RP_SYS_DW-`RP_ADC_DW){smp[`RP_ADC_DW-1]}}, smp}; // sign extend
  end

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) bus_i.ack <= 1'b0;
    else          bus_i.ack <= bus_i.wen | bus_i.ren; // writes acked, no effect
  end

  always_ff @(posedge adc_clk_01) begin
    if (bus_i.wen | bus_i.ren) bus_i.rdata <= bus_i.ren ? rdata_d : '0;
  end

  assign bus_i.err = 1'b0;   // whole region mapped

  // no spontaneous ack
  a_ack_after_strobe: assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    bus_i.ack |-> $past(bus_i.wen || bus_i.ren));

endmodule

// File: design/ams_regs.sv
/* analog mixed signal registers, four pdm duty settings */
`timescale 1ns/1ps
`include "rp_4adc_params.svh"

module ams_regs (
  input  logic                                   adc_clk_01,
  input  logic                                   rst_n_i,
  sys_bus_if.slave                               bus_i,
  output rp_4adc_pkg::pdm_cfg_t [`RP_NUM_ADC-1:0] pdm_cfg_o
);

  import rp_4adc_pkg::*;

  logic [`RP_OFS_W-1:0] ofs;
  logic                 cfg_sel;   // 0x20..0x2c, word aligned
  pdm_cfg_t             cfg_rd;
  sys_word_t            rdata_d;

  assign ofs     = bus_i.addr[`RP_OFS_W-1:0];
  assign cfg_sel = (ofs[`RP_OFS_W-1:4] == 'h2) && (ofs[1:0] == 2'b00);
  assign cfg_rd  = pdm_cfg_o[ofs[3:2]];
  assign rdata_d = cfg_sel ? sys_word_t'(cfg_rd) : '0;   // zero extended

  //////////////////////////////////////////////////
  // settings
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      pdm_cfg_o <= '0;
    end else if (bus_i.wen && cfg_sel) begin
      pdm_cfg_o[ofs[3:2]] <= bus_i.wdata[`RP_PDM_W-1:0];   // low byte only
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) bus_i.ack <= 1'b0;
    else          bus_i.ack <= bus_i.wen | bus_i.ren;
  end

  always_ff @(posedge adc_clk_01) begin
    if (bus_i.wen | bus_i.ren) bus_i.rdata <= bus_i.ren ? rdata_d : '0;
  end

  assign bus_i.err = 1'b0;   // unused offsets are quiet, not errors

endmodule

// File: design/pdm_gen.sv
/* four first-order pulse density modulators, range fixed at 255 */
`timescale 1ns/1ps
`include "rp_4adc_params.svh"

module pdm_gen (
  input  logic                                   adc_clk_01,
  input  logic                                   rst_n_i,
  input  rp_4adc_pkg::pdm_cfg_t [`RP_NUM_ADC-1:0] pdm_cfg_i,
  output logic                  [`RP_NUM_ADC-1:0] dac_pwm_o
);

  import rp_4adc_pkg::*;

  pdm_cfg_t [`RP_NUM_ADC-1:0] acc_r;   // wraps mod 256

  // carry out of acc + setting is the pulse
  // 256 cycles at constant setting -> exactly setting pulses
  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      acc_r     <= '0;
      dac_pwm_o <= '0;
    end else begin
      for (int ch = 0; ch < `RP_NUM_ADC; ch++) begin
        {dac_pwm_o[ch], acc_r[ch]} <= {1'b0, acc_r[ch]} + {1'b0, pdm_cfg_i[ch]};
      end
    end
  end

endmodule

// File: design/rp_4adc_top.sv
/* top of the adc_clk_01 data path: converter, bus decoder,
   housekeeping and ams registers, pdm outputs */
`timescale 1ns/1ps
`include "rp_4adc_params.svh"

module rp_4adc_top (
  input  logic                                      adc_clk_01,
  input  logic                                      rst_n_i,
  // adc
  input  rp_4adc_pkg::adc_raw_t    [`RP_NUM_ADC-1:0] adc_dat_raw_i,
  output rp_4adc_pkg::adc_sample_t [`RP_NUM_ADC-1:0] adc_dat_o,
  // system bus
  input  rp_4adc_pkg::sys_addr_t                     sys_addr_i,
  input  rp_4adc_pkg::sys_word_t                     sys_wdata_i,
  input  logic                                      sys_wen_i,
  input  logic                                      sys_ren_i,
  output rp_4adc_pkg::sys_word_t                     sys_rdata_o,
  output logic                                      sys_ack_o,
  output logic                                      sys_err_o,
  // pdm dac
  output logic                     [`RP_NUM_ADC-1:0] dac_pwm_o
);

  import rp_4adc_pkg::*;

  pdm_cfg_t [`RP_NUM_ADC-1:0] pdm_cfg;

  sys_bus_if bus_hk ();    // region 0
  sys_bus_if bus_ams ();   // region 4

  //////////////////////////////////////////////////
  // adc
  //////////////////////////////////////////////////

  adc_sample_conv i_conv (
    .adc_clk_01    (adc_clk_01),
    .rst_n_i       (rst_n_i),
    .adc_dat_raw_i (adc_dat_raw_i),
    .adc_dat_o     (adc_dat_o)
  );

  //////////////////////////////////////////////////
  // system bus and register blocks
  //////////////////////////////////////////////////

  sys_bus_decode i_decode (
    .adc_clk_01  (adc_clk_01),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .bus_hk_o    (bus_hk),
    .bus_ams_o   (bus_ams)
  );

  hk_regs i_hk (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i),
    .bus_i      (bus_hk),
    .adc_dat_i  (adc_dat_o)    // read-back of converted samples
  );

  ams_regs i_ams (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i),
    .bus_i      (bus_ams),
    .pdm_cfg_o  (pdm_cfg)
  );

  //////////////////////////////////////////////////
  // pdm outputs
  //////////////////////////////////////////////////

  pdm_gen i_pdm (
    .adc_clk_01 (adc_clk_01),
    .rst_n_i    (rst_n_i),
    .pdm_cfg_i  (pdm_cfg),
    .dac_pwm_o  (dac_pwm_o)
  );

endmodule

// File: test/tb_rp_4adc.sv
/* testbench for rp_4adc_top: table of adc, bus and pdm steps,
   random adc words, cycle-count timeout */
`timescale 1ns/1ps
`include "rp_4adc_params.svh"

module tb_rp_4adc;

  import rp_4adc_pkg::*;

  localparam int OP_ADC   = 0;  // addr = raw word, data = channel
  localparam int OP_RD    = 1;
  localparam int OP_WR    = 2;
  localparam int OP_RD2   = 3;  // back-to-back reads, data = second addr
  localparam int OP_PDM   = 4;  // exp holds four settings, one per byte
  localparam int NUM_RAND = 16;

  logic                          adc_clk_01;
  logic                          rst_n_i;
  adc_raw_t    [`RP_NUM_ADC-1:0] adc_dat_raw_i;
  adc_sample_t [`RP_NUM_ADC-1:0] adc_dat_o;
  sys_addr_t                     sys_addr_i;
  sys_word_t                     sys_wdata_i;
  logic                          sys_wen_i;
  logic                          sys_ren_i;
  sys_word_t                     sys_rdata_o;
  logic                          sys_ack_o;
  logic                          sys_err_o;
  logic        [`RP_NUM_ADC-1:0] dac_pwm_o;

  // stimulus table, one entry per index
  string     tname_q[$];
  int        op_q[$];
  sys_addr_t addr_q[$];
  sys_word_t data_q[$];
  sys_word_t exp_q[$];

  integer   seed = 32'h591ba852;
  adc_raw_t raw;
  int       err_cnt = 0;
  int       cycle_cnt = 0;
  int       timeout_limit = 0;

  rp_4adc_top dut_i (
    .adc_clk_01    (adc_clk_01),
    .rst_n_i       (rst_n_i),
    .adc_dat_raw_i (adc_dat_raw_i),
    .adc_dat_o     (adc_dat_o),
    .sys_addr_i    (sys_addr_i),
    .sys_wdata_i   (sys_wdata_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .sys_err_o     (sys_err_o),
    .dac_pwm_o     (dac_pwm_o)
  );

  always #20 adc_clk_01 = ~adc_clk_01;   // 40 ns period

  always @(posedge adc_clk_01) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("TEST FAIL");
      $fatal(1, "simulation hung");
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    err_cnt++;
    $display("error: %s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input sys_word_t exp, input sys_word_t act);
    assert (act === exp) else begin
      err_cnt++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // sign bit kept, 13 magnitude bits flipped
  function automatic adc_sample_t conv_rule(input adc_raw_t r);
    return adc_sample_t'(r ^ {1'b0, {(`RP_ADC_DW-1){1'b1}}});
  endfunction

  // only regions 0 and 4 are mapped
  function automatic logic expect_err(input sys_addr_t addr);
    region_t reg_idx;
    reg_idx = addr[`RP_OFS_W +: `RP_REGION_W];
    return !(reg_idx == region_t'(`RP_HK_REGION) || reg_idx == region_t'(`RP_AMS_REGION));
  endfunction

  task automatic check_response(input string name, input sys_addr_t addr,
                                input sys_word_t exp, input bit is_rd);
    assert (sys_ack_o === 1'b1) else report_error({name, ": no ack two cycles after strobe"});
    check_value({name, " err"}, 32'(expect_err(addr)), 32'(sys_err_o));
    if (is_rd || expect_err(addr))   // unmapped writes read back zero too
      check_value({name, " rdata"}, exp, sys_rdata_o);
  endtask

  //////////////////////////////////////////////////
  // drivers, all start and end 2 ns after an edge
  //////////////////////////////////////////////////

  task automatic drive_strobe(input sys_addr_t addr, input sys_word_t wdata, input bit wr);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
  endtask

  task automatic bus_single(input string name, input sys_addr_t addr, input sys_word_t wdata,
                            input bit wr, input sys_word_t exp);
    drive_strobe(addr, wdata, wr);
    @(posedge adc_clk_01);   // edge N samples the strobe
    #2;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    @(posedge adc_clk_01);
    #1;
    assert (sys_ack_o === 1'b0) else report_error({name, ": ack came one cycle early"});
    @(posedge adc_clk_01);
    #1;
    check_response(name, addr, exp, !wr);
    #1;
  endtask

  task automatic bus_back_to_back(input string name, input sys_addr_t addr_a,
                                  input sys_addr_t addr_b, input sys_word_t exp_b);
    drive_strobe(addr_a, '0, 1'b0);
    @(posedge adc_clk_01);
    #2;
    drive_strobe(addr_b, '0, 1'b0);   // second request while first in flight
    @(posedge adc_clk_01);
    #2;
    sys_ren_i = 1'b0;
    @(posedge adc_clk_01);
    #1;
    check_response({name, " first"}, addr_a, '0, 1'b1);   // unmapped reads zero
    @(posedge adc_clk_01);
    #1;
    check_response({name, " second"}, addr_b, exp_b, 1'b1);
    #1;
  endtask

  task automatic adc_apply(input string name, input int ch, input adc_raw_t r,
                           input adc_sample_t exp);
    adc_dat_raw_i[ch] = r;
    repeat (3) @(posedge adc_clk_01);   // sampled at N, out after N+2
    #1;
    check_value(name, 32'(exp), 32'(adc_dat_o[ch]));
    #1;
  endtask

  task automatic pdm_count(input string name, input sys_word_t exp);
    int cnt [`RP_NUM_ADC];
    for (int ch = 0; ch < `RP_NUM_ADC; ch++)
      cnt[ch] = 0;
    repeat (256) begin
      @(posedge adc_clk_01);
      #1;
      for (int ch = 0; ch < `RP_NUM_ADC; ch++)
        cnt[ch] += int'(dac_pwm_o[ch]);
    end
    #1;
    for (int ch = 0; ch < `RP_NUM_ADC; ch++)
      check_value($sformatf("%s ch%0d", name, ch), 32'(exp[8*ch +: 8]), 32'(cnt[ch]));
  endtask

  task automatic add_entry(input string name, input int op, input sys_addr_t addr,
                           input sys_word_t data, input sys_word_t exp);
    tname_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic fill_table();
    add_entry("adc ch0 zero",    OP_ADC, 32'h0000_0000, 32'd0, 32'h0000_1fff);
    add_entry("adc ch1 midpos",  OP_ADC, 32'h0000_2000, 32'd1, 32'h0000_3fff);
    add_entry("adc ch2 full",    OP_ADC, 32'h0000_3fff, 32'd2, 32'h0000_2000);
    add_entry("adc ch3 mixed",   OP_ADC, 32'h0000_1234, 32'd3, 32'h0000_0dcb);
    add_entry("hk id",           OP_RD,  32'h0000_0000, '0, `RP_ID_WORD);
    add_entry("hk ch0",          OP_RD,  32'h0000_0010, '0, 32'h0000_1fff);
    add_entry("hk ch1",          OP_RD,  32'h0000_0014, '0, 32'hffff_ffff);
    add_entry("hk ch2",          OP_RD,  32'h0000_0018, '0, 32'hffff_e000);
    add_entry("hk ch3",          OP_RD,  32'h0000_001c, '0, 32'h0000_0dcb);
    add_entry("hk write id",     OP_WR,  32'h0000_0000, 32'hdead_beef, '0);  // read only
    add_entry("hk id again",     OP_RD,  32'h0000_0000, '0, `RP_ID_WORD);
    add_entry("hk hole",         OP_RD,  32'h0000_0004, '0, '0);
    add_entry("ams write 0",     OP_WR,  32'h0040_0020, 32'h0000_0100, '0);
    add_entry("ams write 1",     OP_WR,  32'h0040_0024, 32'hffff_ff01, '0);
    add_entry("ams write 2",     OP_WR,  32'h0040_0028, 32'h1234_5680, '0);
    add_entry("ams write 3",     OP_WR,  32'h0040_002c, 32'h0000_00ff, '0);
    add_entry("ams read 0",      OP_RD,  32'h0040_0020, '0, 32'h0000_0000);
    add_entry("ams read 1",      OP_RD,  32'h0040_0024, '0, 32'h0000_0001);
    add_entry("ams read 2",      OP_RD,  32'h0040_0028, '0, 32'h0000_0080);
    add_entry("ams read 3",      OP_RD,  32'h0040_002c, '0, 32'h0000_00ff);
    add_entry("ams hole",        OP_RD,  32'h0040_0030, '0, '0);
    add_entry("pdm density",     OP_PDM, '0, '0, 32'hff80_0100);
    add_entry("region2 read",    OP_RD,  32'h0020_0000, '0, '0);
    add_entry("region2 write",   OP_WR,  32'h0020_0010, 32'h5555_aaaa, '0);
    add_entry("region2 then hk", OP_RD2, 32'h0020_0000, 32'h0000_0000, `RP_ID_WORD);
    add_entry("region7 then ams", OP_RD2, 32'h0070_0000, 32'h0040_0028, 32'h0000_0080);
  endtask

  initial begin
    adc_clk_01    = 1'b0;
    rst_n_i       = 1'b0;
    adc_dat_raw_i = '0;
    sys_addr_i    = '0;
    sys_wdata_i   = '0;
    sys_wen_i     = 1'b0;
    sys_ren_i     = 1'b0;
    fill_table();
    timeout_limit = (tname_q.size() + NUM_RAND) * 8 + 4 * 256;

    repeat (3) @(posedge adc_clk_01);
    #2;
    check_value("reset ack", '0, 32'(sys_ack_o));
    check_value("reset err", '0, 32'(sys_err_o));
    check_value("reset rdata", '0, sys_rdata_o);
    check_value("reset pwm", '0, 32'(dac_pwm_o));
    for (int ch = 0; ch < `RP_NUM_ADC; ch++)
      check_value($sformatf("reset adc ch%0d", ch), '0, 32'(adc_dat_o[ch]));
    rst_n_i = 1'b1;

    for (int i = 0; i < tname_q.size(); i++) begin
      case (op_q[i])
        OP_ADC:  adc_apply(tname_q[i], int'(data_q[i]), adc_raw_t'(addr_q[i]),
                           adc_sample_t'(exp_q[i][`RP_ADC_DW-1:0]));
        OP_RD:   bus_single(tname_q[i], addr_q[i], data_q[i], 1'b0, exp_q[i]);
        OP_WR:   bus_single(tname_q[i], addr_q[i], data_q[i], 1'b1, exp_q[i]);
        OP_RD2:  bus_back_to_back(tname_q[i], addr_q[i], data_q[i], exp_q[i]);
        OP_PDM:  pdm_count(tname_q[i], exp_q[i]);
        default: report_error($sformatf("unknown table operation at entry %0d", i));
      endcase
    end

    // random words spread over the channels
    for (int i = 0; i < NUM_RAND; i++) begin
      raw = adc_raw_t'($random(seed));
      adc_apply($sformatf("adc random %0d", i), i % `RP_NUM_ADC, raw, conv_rule(raw));
    end

    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+include
design/rp_4adc_pkg.sv
design/sys_bus_if.sv
design/adc_sample_conv.sv
design/sys_bus_decode.sv
design/hk_regs.sv
design/ams_regs.sv
design/pdm_gen.sv
design/rp_4adc_top.sv
test/tb_rp_4adc.sv

// File: Makefile
# Verilator build, run and lint of the four-channel acquisition data path

VERILATOR ?= verilator
TOP       ?= tb_rp_4adc
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module rp_4adc_top

clean:
	rm -rf $(OBJ_DIR) $(LOG)
